/* src/pathGeomPkg.sv */
// path geometry of the ORAM tree, all sizes counted in DRAM bursts
// a path holds levels+1 buckets, one header burst per bucket
`default_nettype none

package pathGeomPkg;

	// buckets on one root-to-leaf path
	function automatic int bucketsOnPath(input int levels);
		return levels + 1;
	endfunction

	// bursts on one path
	function automatic int pathBursts(input int levels, input int bktBursts);
		return bktBursts * bucketsOnPath(levels);
	endfunction

	// two path regions plus one header per bucket
	function automatic int bufAddrWidth(input int levels, input int bktBursts);
		return $clog2(2 * pathBursts(levels, bktBursts) + bucketsOnPath(levels));
	endfunction

	// counter width for a wrap threshold n
	function automatic int ctrWidth(input int n);
		int w;
		w = $clog2(n);
		if (w < 1)
			w = 1;
		return w;
	endfunction

endpackage

`default_nettype wire

/* src/bufMapPkg.sv */
// access kinds and region offsets inside the path buffer
// payload of interest shares offset 0 with the input path region
`default_nettype none

package bufMapPkg;

	typedef enum logic [1:0] {
		idle      = 2'd0,
		readWrite = 2'd1,
		readOnly  = 2'd2
	} accessKind;

	// ========================================
	// region offsets
	// ========================================
	function automatic int inPathBase();
		return 0;
	endfunction

	function automatic int outPathBase(input int levels, input int bktBursts);
		return pathGeomPkg::pathBursts(levels, bktBursts);
	endfunction

	function automatic int bktOfIBase();
		return 0;
	endfunction

	function automatic int headerBase(input int levels, input int bktBursts);
		return 2 * pathGeomPkg::pathBursts(levels, bktBursts); // after both path regions
	endfunction

endpackage

`default_nettype wire

/* src/bufPortIf.sv */
// single port request into the path buffer
// enable with write stores din, enable alone reads with one cycle latency
`timescale 1ns/1ps
`default_nettype none

interface bufPortIf #(
	parameter int dataWidth = 64,
	parameter int addrWidth = 6
);

	logic                 enable;
	logic                 write;
	logic [addrWidth-1:0] address;
	logic [dataWidth-1:0] din;

	// port owner
	modport arbiter (output enable, write, address, din);

	// buffer memory side
	modport ram (input enable, write, address, din);

endinterface

`default_nettype wire

/* src/burstCounter.sv */
// counts enabled cycles from 0 to threshold-1 and then wraps
// done is combinational and only high in the enabled cycle that wraps
`timescale 1ns/1ps
`default_nettype none

module burstCounter #(
	parameter int threshold = 4
) (
	input  logic                                        Clock,
	input  logic                                        rstN,
	input  logic                                        enable,
	output logic [pathGeomPkg::ctrWidth(threshold)-1:0] count,
	output logic                                        done
);

	localparam int width = pathGeomPkg::ctrWidth(threshold);
	localparam logic [width-1:0] lastCount = width'(threshold - 1);

	assign done = enable && (count == lastCount);

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			count <= '0;
		end else if (enable) begin
			if (done)
				count <= '0; // wrap
			else
				count <= count + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* src/accessModeRegs.sv */
// access kind and phase, loaded by one-cycle command strobes
// read/write writeback ends on its second path wrap, the first only fills the output region
// start strobes are assumed mutually exclusive
`timescale 1ns/1ps
`default_nettype none

module accessModeRegs (
	input  logic                  Clock,
	input  logic                  rstN,
	input  logic                  startRw,
	input  logic                  startRo,
	input  logic                  startWriteback,
	input  logic                  pathDone,
	input  logic                  headerDone,
	output bufMapPkg::accessKind  kind,
	output logic                  pathRead
);

	logic outFilled; // stash has filled the output region

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			kind      <= bufMapPkg::idle;
			pathRead  <= 1'b0;
			outFilled <= 1'b0;
		end else if (startRw) begin
			kind      <= bufMapPkg::readWrite;
			pathRead  <= 1'b1;
			outFilled <= 1'b0;
		end else if (startRo) begin
			kind      <= bufMapPkg::readOnly;
			pathRead  <= 1'b1;
			outFilled <= 1'b0;
		end else if (startWriteback) begin
			pathRead <= 1'b0;
		end else if (!pathRead) begin
			// writeback completion
			if (kind == bufMapPkg::readWrite && pathDone) begin
				if (outFilled) begin
					kind      <= bufMapPkg::idle; // output region sent to AES
					outFilled <= 1'b0;
				end else begin
					outFilled <= 1'b1;
				end
			end
			if (kind == bufMapPkg::readOnly && headerDone)
				kind <= bufMapPkg::idle; // all headers sent
		end
	end

endmodule

`default_nettype wire

/* src/portArbiter.sv */
// picks the single user of the path buffer port each cycle
// request outputs are combinational, directions flip on counter wrap edges
// reads to AES need freeCount > readInFlight so the feed queue cannot overflow
`timescale 1ns/1ps
`default_nettype none

module portArbiter #(
	parameter int dataWidth = 64,
	parameter int levels    = 3,
	parameter int bktBursts = 4
) (
	input  logic                 Clock,
	input  logic                 rstN,
	input  bufMapPkg::accessKind kind,
	input  logic                 pathRead,
	input  logic                 decXfer,
	input  logic [dataWidth-1:0] decData,
	input  logic                 stashXfer,
	input  logic [dataWidth-1:0] stashData,
	input  logic [dataWidth-1:0] headerData,
	input  logic                 ivDone,
	input  logic                 ivDoneBkt,
	input  logic [1:0]           freeCount,
	output logic                 readInFlight,
	output logic                 pathDone,
	output logic                 headerDone,
	output logic                 bucketDone,
	bufPortIf.arbiter            port
);

	localparam int pathLen   = pathGeomPkg::pathBursts(levels, bktBursts);
	localparam int hdrLen    = pathGeomPkg::bucketsOnPath(levels);
	localparam int addrWidth = pathGeomPkg::bufAddrWidth(levels, bktBursts);

	localparam logic [addrWidth-1:0] inBase  = addrWidth'(bufMapPkg::inPathBase());
	localparam logic [addrWidth-1:0] outBase =
		addrWidth'(bufMapPkg::outPathBase(levels, bktBursts));
	localparam logic [addrWidth-1:0] bktBase = addrWidth'(bufMapPkg::bktOfIBase());
	localparam logic [addrWidth-1:0] hdrBase =
		addrWidth'(bufMapPkg::headerBase(levels, bktBursts));

	logic [pathGeomPkg::ctrWidth(pathLen)-1:0]   pathCount;
	logic [pathGeomPkg::ctrWidth(hdrLen)-1:0]    headerCount;
	logic [pathGeomPkg::ctrWidth(bktBursts)-1:0] bucketCount;

	logic isRw, isRo;
	logic pathDir;   // 1 writes the buffer, 0 reads it out
	logic headerDir; // same for the header region
	logic bucketOfI;
	logic canSend;

	assign isRw      = (kind == bufMapPkg::readWrite);
	assign isRo      = (kind == bufMapPkg::readOnly);
	assign bucketOfI = isRo && pathRead && !headerDir; // headers done, payload follows
	assign canSend   = freeCount > {1'b0, readInFlight};

	// ========================================
	// progress counters
	// ========================================
	burstCounter #(.threshold(pathLen)) i_pathCtr (
		.Clock  (Clock),
		.rstN   (rstN),
		.enable (isRw && port.enable),
		.count  (pathCount),
		.done   (pathDone)
	);

	burstCounter #(.threshold(hdrLen)) i_headerCtr (
		.Clock  (Clock),
		.rstN   (rstN),
		.enable (isRo && port.enable && !bucketOfI),
		.count  (headerCount),
		.done   (headerDone)
	);

	burstCounter #(.threshold(bktBursts)) i_bucketCtr (
		.Clock  (Clock),
		.rstN   (rstN),
		.enable (decXfer && bucketOfI),
		.count  (bucketCount),
		.done   (bucketDone)
	);

	// ========================================
	// direction and read tracking
	// ========================================
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			pathDir      <= 1'b1;
			headerDir    <= 1'b1;
			readInFlight <= 1'b0;
		end else begin
			if (isRw && !pathRead && pathDone)
				pathDir <= !pathDir; // stash fill done, or readout done
			if (isRo && headerDone)
				headerDir <= !headerDir;
			readInFlight <= port.enable && !port.write; // data on RAM output next cycle
		end
	end

	// ========================================
	// port request
	// ========================================
	always_comb begin
		port.enable  = 1'b0;
		port.write   = 1'b0;
		port.address = '0;
		port.din     = '0;
		case (kind)
			bufMapPkg::readWrite: begin
				if (pathRead) begin
					port.enable  = decXfer;
					port.write   = 1'b1;
					port.address = inBase + addrWidth'(pathCount);
					port.din     = decData;
				end else begin
					// stash fill first, then readout to AES
					port.enable  = pathDir ? stashXfer : (ivDone && canSend);
					port.write   = pathDir;
					port.address = outBase + addrWidth'(pathCount);
					port.din     = stashData;
				end
			end
			bufMapPkg::readOnly: begin
				if (pathRead)
					port.enable = decXfer; // headers, then payload of interest
				else
					port.enable = !headerDir && ivDoneBkt && canSend;
				port.write = pathRead || headerDir;
				if (bucketOfI) begin
					port.address = bktBase + addrWidth'(bucketCount);
					port.din     = decData;
				end else begin
					port.address = hdrBase + addrWidth'(headerCount);
					port.din     = headerData;
				end
			end
			default: ; // idle, port unused
		endcase
	end

endmodule

`default_nettype wire

/* src/pathBufferRam.sv */
// single port path buffer, contents undefined after power up
// read data is registered and holds until the next read
`timescale 1ns/1ps
`default_nettype none

module pathBufferRam #(
	parameter int dataWidth = 64,
	parameter int levels    = 3,
	parameter int bktBursts = 4
) (
	input  logic                 Clock,
	bufPortIf.ram                port,
	output logic [dataWidth-1:0] rdata
);

	localparam int addrWidth = pathGeomPkg::bufAddrWidth(levels, bktBursts);
	localparam int depth     = 2 ** addrWidth;

	logic [dataWidth-1:0] mem [depth];

	// ========================================
	// write and registered read
	// ========================================
	always_ff @(posedge Clock) begin
		if (port.enable) begin
			if (port.write)
				mem[port.address] <= port.din;
			else
				rdata <= mem[port.address]; // one cycle latency
		end
	end

endmodule

`default_nettype wire

/* src/aesFeedQueue.sv */
// two entry FIFO between the path buffer and AES
// head word is shown combinationally while valid is high
// a push into a full queue is dropped unless a take frees a slot in the same cycle
`timescale 1ns/1ps
`default_nettype none

module aesFeedQueue #(
	parameter int dataWidth = 64
) (
	input  logic                 Clock,
	input  logic                 rstN,
	input  logic                 push,
	input  logic [dataWidth-1:0] pushData,
	input  logic                 take,
	output logic [dataWidth-1:0] headData,
	output logic                 valid,
	output logic [1:0]           freeCount
);

	logic [dataWidth-1:0] slots [2];
	logic                 wrPtr;
	logic                 rdPtr;
	logic [1:0]           used;
	logic                 doPush;
	logic                 doTake;

	assign doTake = take && (used != 2'd0);                  // take while empty is ignored
	assign doPush = push && ((used != 2'd2) || doTake);

	// payload storage
	always_ff @(posedge Clock) begin
		if (doPush)
			slots[wrPtr] <= pushData;
	end

	// ========================================
	// pointers and fill level
	// ========================================
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			wrPtr <= 1'b0;
			rdPtr <= 1'b0;
			used  <= 2'd0;
		end else begin
			wrPtr <= wrPtr ^ doPush;
			rdPtr <= rdPtr ^ doTake;
			used  <= used + 2'(doPush) - 2'(doTake);
		end
	end

	assign headData  = slots[rdPtr];
	assign valid     = (used != 2'd0);
	assign freeCount = 2'd2 - used;

endmodule

`default_nettype wire

/* src/pathBufferTop.sv */
// path buffer port of the ORAM controller
// command and data strobes are one cycle pulses, ivDone and ivDoneBkt are levels
// aesTake removes the head word shown on aesData while aesValid is high
`timescale 1ns/1ps
`default_nettype none

module pathBufferTop #(
	parameter int dataWidth = 64,
	parameter int levels    = 3,
	parameter int bktBursts = 4
) (
	input  logic                 Clock,
	input  logic                 rstN,
	input  logic                 startRw,
	input  logic                 startRo,
	input  logic                 startWriteback,
	input  logic                 decXfer,
	input  logic [dataWidth-1:0] decData,
	input  logic                 stashXfer,
	input  logic [dataWidth-1:0] stashData,
	input  logic [dataWidth-1:0] headerData,
	input  logic                 ivDone,
	input  logic                 ivDoneBkt,
	input  logic                 aesTake,
	output logic [dataWidth-1:0] aesData,
	output logic                 aesValid,
	output logic                 pathDone,
	output logic                 headerDone,
	output logic                 bucketDone
);

	localparam int addrWidth = pathGeomPkg::bufAddrWidth(levels, bktBursts);

	bufMapPkg::accessKind kind;
	logic                 pathRead;
	logic                 readInFlight;
	logic [1:0]           freeCount;
	logic [dataWidth-1:0] ramData;

	bufPortIf #(.dataWidth(dataWidth), .addrWidth(addrWidth)) bufPort ();

	// ========================================
	// control
	// ========================================
	accessModeRegs i_modeRegs (
		.Clock          (Clock),
		.rstN           (rstN),
		.startRw        (startRw),
		.startRo        (startRo),
		.startWriteback (startWriteback),
		.pathDone       (pathDone),
		.headerDone     (headerDone),
		.kind           (kind),
		.pathRead       (pathRead)
	);

	portArbiter #(
		.dataWidth (dataWidth),
		.levels    (levels),
		.bktBursts (bktBursts)
	) i_portArbiter (
		.Clock        (Clock),
		.rstN         (rstN),
		.kind         (kind),
		.pathRead     (pathRead),
		.decXfer      (decXfer),
		.decData      (decData),
		.stashXfer    (stashXfer),
		.stashData    (stashData),
		.headerData   (headerData),
		.ivDone       (ivDone),
		.ivDoneBkt    (ivDoneBkt),
		.freeCount    (freeCount),
		.readInFlight (readInFlight),
		.pathDone     (pathDone),
		.headerDone   (headerDone),
		.bucketDone   (bucketDone),
		.port         (bufPort.arbiter)
	);

	// ========================================
	// datapath
	// ========================================
	pathBufferRam #(
		.dataWidth (dataWidth),
		.levels    (levels),
		.bktBursts (bktBursts)
	) i_pathBufferRam (
		.Clock (Clock),
		.port  (bufPort.ram),
		.rdata (ramData)
	);

	aesFeedQueue #(.dataWidth(dataWidth)) i_aesFeedQueue (
		.Clock     (Clock),
		.rstN      (rstN),
		.push      (readInFlight), // RAM word ready this cycle
		.pushData  (ramData),
		.take      (aesTake),
		.headData  (aesData),
		.valid     (aesValid),
		.freeCount (freeCount)
	);

endmodule

`default_nettype wire

/* test/tbClockGen.sv */
// free running clock for the testbench, first rising edge at half a period
// rstN is low for the first resetCycles rising edges and released 1 ns after the last
`timescale 1ns/1ps
`default_nettype none

module tbClockGen #(
	parameter int periodNs    = 100,
	parameter int resetCycles = 2
) (
	output logic Clock,
	output logic rstN
);

	initial begin
		Clock = 1'b0;
		forever #(periodNs / 2) Clock = ~Clock;
	end

	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge Clock);
		#1 rstN = 1'b1; // same skew as the stimulus
	end

endmodule

`default_nettype wire

/* test/pathBufferTb_sva.sv */
// assertions bound into pathBufferTop on its ports only
// failCount holds the number of failed assertions in this run
`timescale 1ns/1ps
`default_nettype none

module pathBufferTb_sva #(
	parameter int dataWidth = 64
) (
	input logic                 Clock,
	input logic                 rstN,
	input logic                 startRw,
	input logic                 startRo,
	input logic                 ivDone,
	input logic                 ivDoneBkt,
	input logic [dataWidth-1:0] aesData,
	input logic                 aesValid,
	input logic                 pathDone,
	input logic                 headerDone,
	input logic                 bucketDone
);

	int   failCount = 0;
	logic seenStart; // an access has been started since reset

	always_ff @(posedge Clock) begin
		if (!rstN)
			seenStart <= 1'b0;
		else if (startRw || startRo)
			seenStart <= 1'b1;
	end

	// ========================================
	// port properties
	// ========================================
	quietUntilStart: assert property (@(posedge Clock) disable iff (!rstN)
		!seenStart |-> !(aesValid || pathDone || headerDone || bucketDone))
	else begin
		failCount++;
		$error("AES or done output active before the first start strobe");
	end

	// each read needs an IV level two edges before its word shows
	validNeedsIv: assert property (@(posedge Clock) disable iff (!rstN)
		$rose(aesValid) |-> $past(ivDone || ivDoneBkt, 2))
	else begin
		failCount++;
		$error("aesValid rose although no IV was ready when the read was issued");
	end

	donePulsesShort: assert property (@(posedge Clock) disable iff (!rstN)
		(pathDone || headerDone || bucketDone) |=> !(pathDone || headerDone || bucketDone))
	else begin
		failCount++;
		$error("a done pulse lasted longer than one cycle");
	end

	donesExclusive: assert property (@(posedge Clock) disable iff (!rstN)
		$onehot0({pathDone, headerDone, bucketDone}))
	else begin
		failCount++;
		$error("two done pulses in the same cycle");
	end

	dataKnown: assert property (@(posedge Clock) disable iff (!rstN)
		aesValid |-> !$isunknown(aesData))
	else begin
		failCount++;
		$error("aesData unknown while aesValid is high");
	end

endmodule

bind pathBufferTop pathBufferTb_sva #(.dataWidth(dataWidth)) i_pathBufferSva (
	.Clock      (Clock),
	.rstN       (rstN),
	.startRw    (startRw),
	.startRo    (startRo),
	.ivDone     (ivDone),
	.ivDoneBkt  (ivDoneBkt),
	.aesData    (aesData),
	.aesValid   (aesValid),
	.pathDone   (pathDone),
	.headerDone (headerDone),
	.bucketDone (bucketDone)
);

`default_nettype wire

/* test/pathBufferTb.sv */
// drives one read/write access and one read-only access through the path buffer
// expected AES words are kept in a queue model, inputs change 1 ns after the rising edge
`timescale 1ns/1ps
`default_nettype none

module pathBufferTb;

	localparam int dataWidth   = 64;
	localparam int levels      = 3;
	localparam int bktBursts   = 4;
	localparam int clockPeriod = 100;
	localparam int hdrLen      = levels + 1;
	localparam int pathLen     = bktBursts * hdrLen;
	// fills, readout with takes, commands and idle gaps
	localparam int stimCycles  = 30 + 4 * pathLen + 4 * pathLen + 8 * hdrLen + 2 * bktBursts;

	logic                 Clock, rstN;
	logic                 startRw, startRo, startWriteback;
	logic                 decXfer, stashXfer, ivDone, ivDoneBkt, aesTake;
	logic [dataWidth-1:0] decData, stashData, headerData, aesData;
	logic                 aesValid, pathDone, headerDone, bucketDone;
	logic [dataWidth-1:0] expectQ [$]; // words due at AES, oldest first

	tbClockGen #(.periodNs(clockPeriod), .resetCycles(2)) i_clockGen (
		.Clock (Clock),
		.rstN  (rstN)
	);

	pathBufferTop #(
		.dataWidth (dataWidth),
		.levels    (levels),
		.bktBursts (bktBursts)
	) i_pathBufferTop (
		.Clock          (Clock),
		.rstN           (rstN),
		.startRw        (startRw),
		.startRo        (startRo),
		.startWriteback (startWriteback),
		.decXfer        (decXfer),
		.decData        (decData),
		.stashXfer      (stashXfer),
		.stashData      (stashData),
		.headerData     (headerData),
		.ivDone         (ivDone),
		.ivDoneBkt      (ivDoneBkt),
		.aesTake        (aesTake),
		.aesData        (aesData),
		.aesValid       (aesValid),
		.pathDone       (pathDone),
		.headerDone     (headerDone),
		.bucketDone     (bucketDone)
	);

	// ========================================
	// helpers
	// ========================================
	task automatic failRun();
		$display("Testbench failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic nextCycle();
		@(posedge Clock);
		#1;
	endtask

	function automatic logic [dataWidth-1:0] randomWord();
		return dataWidth'({$urandom(), $urandom()});
	endfunction

	task automatic checkValue(input string name, input logic [dataWidth-1:0] got,
			input logic [dataWidth-1:0] want);
		assert (got === want) else begin
			$display("[FAIL] time %0t: %s = %0h, expected %0h", $time, name, got, want);
			failRun();
		end
	endtask

	task automatic issueCommand(input logic rw, input logic ro, input logic wb);
		startRw        = rw;
		startRo        = ro;
		startWriteback = wb;
		nextCycle();
		startRw        = 1'b0;
		startRo        = 1'b0;
		startWriteback = 1'b0;
		nextCycle();
	endtask

	// one strobe then a quiet cycle, done pulses sampled mid cycle
	task automatic sendBurst(input logic fromStash, input logic [dataWidth-1:0] word,
			input logic [2:0] wantDone);
		decXfer   = !fromStash;
		stashXfer = fromStash;
		if (fromStash)
			stashData = word;
		else
			decData = word;
		@(negedge Clock);
		checkValue("{pathDone,headerDone,bucketDone}", {pathDone, headerDone, bucketDone},
			wantDone);
		nextCycle();
		decXfer   = 1'b0;
		stashXfer = 1'b0;
		nextCycle();
	endtask

	task automatic waitValid(input int maxCycles);
		int n;
		n = 0;
		while (!aesValid && n < maxCycles) begin
			nextCycle();
			n++;
		end
		assert (aesValid) else begin
			$display("no word reached AES within %0d cycles at time %0t", maxCycles, $time);
			failRun();
		end
	endtask

	// a take while aesValid is low must leave everything as it was
	task automatic takeWord();
		logic [dataWidth-1:0] want;
		if (aesValid) begin
			assert (expectQ.size() > 0) else begin
				$display("AES got a word the model did not expect at time %0t", $time);
				failRun();
			end
			want = expectQ.pop_front();
			checkValue("aesData", aesData, want);
		end
		aesTake = 1'b1;
		nextCycle();
		aesTake = 1'b0;
	endtask

	// ========================================
	// stimulus
	// ========================================
	initial begin
		logic [dataWidth-1:0] word;
		void'($urandom(32'h1ded_aa85));
		startRw        = 1'b0;
		startRo        = 1'b0;
		startWriteback = 1'b0;
		decXfer        = 1'b0;
		stashXfer      = 1'b0;
		ivDone         = 1'b0;
		ivDoneBkt      = 1'b0;
		aesTake        = 1'b0;
		decData        = '0;
		stashData      = '0;
		headerData     = '0;
		wait (rstN === 1'b1);
		repeat (4) nextCycle(); // outputs must stay quiet here

		takeWord(); // stray take, queue empty
		checkValue("aesValid", aesValid, 1'b0);

		// read/write access, path read then stash fill
		issueCommand(1'b1, 1'b0, 1'b0);
		for (int i = 0; i < pathLen; i++)
			sendBurst(1'b0, randomWord(), (i == pathLen - 1) ? 3'b100 : 3'b000);
		issueCommand(1'b0, 1'b0, 1'b1);
		for (int i = 0; i < pathLen; i++) begin
			word = randomWord();
			expectQ.push_back(word);
			sendBurst(1'b1, word, (i == pathLen - 1) ? 3'b100 : 3'b000);
		end
		repeat (6) nextCycle(); // ivDone still low

		// readout, first stalled by the full queue
		ivDone = 1'b1;
		waitValid(10);
		repeat (8) nextCycle();
		checkValue("aesValid", aesValid, 1'b1);
		for (int i = 0; i < pathLen; i++) begin
			waitValid(10);
			takeWord();
		end
		ivDone = 1'b0;
		takeWord();
		checkValue("aesValid", aesValid, 1'b0);

		// read-only access, headers then bucket of interest
		issueCommand(1'b0, 1'b1, 1'b0);
		for (int i = 0; i < hdrLen; i++) begin
			word       = randomWord();
			headerData = word;
			expectQ.push_back(word);
			sendBurst(1'b0, randomWord(), (i == hdrLen - 1) ? 3'b010 : 3'b000);
		end
		headerData = randomWord();
		for (int i = 0; i < bktBursts; i++)
			sendBurst(1'b0, randomWord(), (i == bktBursts - 1) ? 3'b001 : 3'b000);
		issueCommand(1'b0, 1'b0, 1'b1);
		ivDoneBkt = 1'b1;
		for (int i = 0; i < hdrLen; i++) begin
			waitValid(10);
			takeWord();
		end
		ivDoneBkt = 1'b0;
		repeat (4) nextCycle();

		if (expectQ.size() == 0 && i_pathBufferTop.i_pathBufferSva.failCount == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("%0d words never reached AES or a bound assertion failed",
				expectQ.size());
			failRun();
		end
	end

	// stop at the first bound assertion failure
	initial begin
		wait (i_pathBufferTop.i_pathBufferSva.failCount != 0);
		$display("a bound assertion failed at time %0t", $time);
		failRun();
	end

	initial begin
		#(3 * stimCycles * clockPeriod);
		$display("watchdog expired, the run did not finish in time");
		failRun();
	end

endmodule

`default_nettype wire

/* sources.f */
src/pathGeomPkg.sv
src/bufMapPkg.sv
src/bufPortIf.sv
src/burstCounter.sv
src/accessModeRegs.sv
src/portArbiter.sv
src/pathBufferRam.sv
src/aesFeedQueue.sv
src/pathBufferTop.sv
test/tbClockGen.sv
test/pathBufferTb_sva.sv
test/pathBufferTb.sv
